/* Makefile */
# verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) vlog.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f vlog.f

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* icache_ctrl.sv */
// request FSM, refill and counters

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_ctrl (
    input  logic                                  clk,
    input  logic                                  rst,
    // cpu
    input  logic [`ICACHE_ADDR_BITS-1:0]          cpu_addr_i,
    input  logic                                  cpu_valid_i,
    input  logic                                  cpu_consume_i,
    input  logic                                  cpu_clean_i,
    output logic [`ICACHE_LINE_BITS-1:0]          cpu_data_o,
    output logic                                  cpu_ready_o,
    output logic                                  cache_clear_o,
    // read bus
    output logic                                  axi_valid_o,
    output logic [`ICACHE_ADDR_BITS-1:0]          axi_addr_o,
    input  logic                                  axi_ready_i,
    input  logic                                  axi_last_i,
    input  logic [`ICACHE_BEAT_BITS-1:0]          axi_data_i,
    // counters
    output logic [`ICACHE_CNT_BITS-1:0]           hit_count_o,
    output logic [`ICACHE_CNT_BITS-1:0]           miss_count_o,
    // tag store
    output logic [`ICACHE_IDX_BITS-1:0]           lookup_index_o,
    output logic [`ICACHE_TAG_BITS-1:0]           lookup_tag_o,
    output logic                                  lookup_en_o,
    output logic                                  fill_en_o,
    output icache_pkg::icache_fill_t              fill_o,
    input  icache_pkg::icache_lookup_t            lookup_i,
    // srams
    output logic [`ICACHE_RAMS-1:0]               ram_ce_o,
    output logic [`ICACHE_RAMS-1:0]               ram_we_o,
    output logic [`ICACHE_RAM_AW-1:0]             ram_addr_o,
    output logic [`ICACHE_LINE_BITS-1:0]          ram_wdata_o,
    input  logic [`ICACHE_RAMS-1:0][`ICACHE_LINE_BITS-1:0] ram_rdata_i
);

    import icache_pkg::*;

    icache_state_e                state_q;
    icache_addr_u                 cpu_addr;
    icache_addr_u                 req_q;       // request being served
    logic [`ICACHE_WAY_BITS-1:0]  victim_q;
    logic [`ICACHE_LINE_BITS-1:0] line_q;      // refill line
    logic                         beat_q;      // next beat is the upper half
    logic                         fill_q;      // line complete, write this cycle
    logic                         abandon_q;   // clean seen during refill
    logic                         rd_en;
    logic [`ICACHE_IDX_BITS-1:0]  ram_idx;

    assign cpu_addr      = cpu_addr_i;
    assign cache_clear_o = (state_q == IDLE);

    assign lookup_index_o = req_q.f.index;
    assign lookup_tag_o   = req_q.f.tag;
    // no age update when the cpu walks away
    assign lookup_en_o    = (state_q == LOOKUP) && !cpu_clean_i;
    assign fill_en_o      = (state_q == REFILL) && fill_q;

    always_comb begin
        fill_o.index = req_q.f.index;
        fill_o.tag   = req_q.f.tag;
        fill_o.way   = victim_q;
    end

    // read is issued from idle so the line is ready in lookup
    assign rd_en      = (state_q == IDLE) && cpu_valid_i;
    assign ram_idx    = rd_en ? cpu_addr.f.index : req_q.f.index;
    assign ram_addr_o = ram_idx[`ICACHE_RAM_AW-1:0];
    assign ram_wdata_o = line_q;

    // sram r serves way r/2 in bank r%2
    always_comb begin
        for (int r = 0; r < `ICACHE_RAMS; r++) begin
            ram_we_o[r] = fill_en_o && (victim_q == r[`ICACHE_WAY_BITS:1]);
            ram_ce_o[r] = (ram_idx[`ICACHE_IDX_BITS-1] == r[0]) && (rd_en || ram_we_o[r]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= IDLE;
            req_q        <= '0;
            cpu_ready_o  <= 1'b0;
            axi_valid_o  <= 1'b0;
            beat_q       <= 1'b0;
            fill_q       <= 1'b0;
            abandon_q    <= 1'b0;
            hit_count_o  <= '0;
            miss_count_o <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (cpu_valid_i) begin
                        req_q   <= cpu_addr;
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (cpu_clean_i) begin
                        state_q <= IDLE;
                    end else if (lookup_i.hit) begin
                        cpu_data_o  <= ram_rdata_i[{lookup_i.hit_way,
                                                    req_q.f.index[`ICACHE_IDX_BITS-1]}];
                        cpu_ready_o <= 1'b1;
                        hit_count_o <= hit_count_o + 1'b1;
                        state_q     <= HOLD;
                    end else begin
                        victim_q     <= lookup_i.victim_way;
                        axi_valid_o  <= 1'b1;
                        axi_addr_o   <= {req_q.word[`ICACHE_ADDR_BITS-1:`ICACHE_OFF_BITS],
                                         {`ICACHE_OFF_BITS{1'b0}}};
                        miss_count_o <= miss_count_o + 1'b1;
                        state_q      <= REFILL;
                    end
                end
                REFILL: begin
                    if (fill_q) begin
                        // line goes into the sram and tag store at this edge
                        fill_q    <= 1'b0;
                        abandon_q <= 1'b0;
                        if (abandon_q || cpu_clean_i) begin
                            state_q <= IDLE;
                        end else begin
                            cpu_data_o  <= line_q;
                            cpu_ready_o <= 1'b1;
                            state_q     <= HOLD;
                        end
                    end else begin
                        if (cpu_clean_i) begin
                            abandon_q <= 1'b1;
                        end
                        if (axi_valid_o && axi_ready_i) begin
                            line_q[beat_q*`ICACHE_BEAT_BITS +: `ICACHE_BEAT_BITS] <= axi_data_i;
                            beat_q <= ~beat_q;
                            if (axi_last_i) begin
                                axi_valid_o <= 1'b0;
                                beat_q      <= 1'b0;
                                fill_q      <= 1'b1;
                            end
                        end
                    end
                end
                HOLD: begin
                    if (cpu_consume_i || cpu_clean_i) begin
                        cpu_ready_o <= 1'b0;
                        state_q     <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // request must stay up until the responder has sent the last beat
    a_axi_valid_hold: assert property (
        @(posedge clk) disable iff (rst)
        axi_valid_o && !(axi_ready_i && axi_last_i) |=> axi_valid_o
    ) else $error("bus request dropped before last beat");

    a_no_ready_in_refill: assert property (
        @(posedge clk) disable iff (rst) (state_q == REFILL) |-> !cpu_ready_o
    ) else $error("cpu ready raised during refill");

endmodule

/* icache_defs.svh */
// instruction cache sizing

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// organisation
`define ICACHE_WAYS       4
`define ICACHE_WAY_BITS   2
`define ICACHE_SETS       128
`define ICACHE_IDX_BITS   7
`define ICACHE_TAG_BITS   21
`define ICACHE_OFF_BITS   4

// data widths
`define ICACHE_ADDR_BITS  32
`define ICACHE_LINE_BITS  128
`define ICACHE_BEAT_BITS  64

// each way spans two sram banks picked by the index msb
`define ICACHE_RAM_DEPTH  64
`define ICACHE_RAM_AW     6
`define ICACHE_RAMS       (2 * `ICACHE_WAYS)

// performance counters
`define ICACHE_CNT_BITS   64

`endif

/* icache_pkg.sv */
// instruction cache types

`include "icache_defs.svh"

package icache_pkg;

    // fetch address split for lookup
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0] tag;
        logic [`ICACHE_IDX_BITS-1:0] index;
        logic [`ICACHE_OFF_BITS-1:0] offset;
    } icache_addr_fields_t;

    typedef union packed {
        logic [`ICACHE_ADDR_BITS-1:0] word;    // raw, for bus address
        icache_addr_fields_t          f;
    } icache_addr_u;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        HOLD
    } icache_state_e;

    typedef struct packed {
        logic                         hit;
        logic [`ICACHE_WAY_BITS-1:0]  hit_way;
        logic [`ICACHE_WAY_BITS-1:0]  victim_way;
    } icache_lookup_t;

    typedef struct packed {
        logic [`ICACHE_IDX_BITS-1:0]  index;
        logic [`ICACHE_TAG_BITS-1:0]  tag;
        logic [`ICACHE_WAY_BITS-1:0]  way;
    } icache_fill_t;

endpackage

/* icache_sram.sv */
// single-port line sram model

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_sram (
    input  logic                         clk,
    input  logic                         ce_i,
    input  logic                         we_i,
    input  logic [`ICACHE_RAM_AW-1:0]    addr_i,
    input  logic [`ICACHE_LINE_BITS-1:0] wdata_i,
    output logic [`ICACHE_LINE_BITS-1:0] rdata_o
);

    logic [`ICACHE_LINE_BITS-1:0] mem [`ICACHE_RAM_DEPTH];

    // write or read, never both in one cycle
    always_ff @(posedge clk) begin
        if (ce_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];   // holds until next enabled read
            end
        end
    end

    // an X address would corrupt or read an arbitrary row
    a_addr_known: assert property (
        @(posedge clk) ce_i |-> !$isunknown({we_i, addr_i})
    ) else $error("sram enabled with unknown address or write enable");

endmodule

/* icache_tag_store.sv */
// tag, valid and age arrays
// hit compare and victim choice

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_tag_store (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`ICACHE_IDX_BITS-1:0]   index_i,
    input  logic [`ICACHE_TAG_BITS-1:0]   tag_i,
    input  logic                          lookup_en_i,
    input  logic                          fill_en_i,
    input  icache_pkg::icache_fill_t      fill_i,
    output icache_pkg::icache_lookup_t    lookup_o
);

    logic [`ICACHE_TAG_BITS-1:0] tag_q   [`ICACHE_SETS][`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0]     valid_q [`ICACHE_SETS];
    logic [1:0]                  age_q   [`ICACHE_SETS][`ICACHE_WAYS];

    logic [`ICACHE_WAYS-1:0]     hit_vec;

    // tag write on a fill
    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            tag_q[fill_i.index][fill_i.way] <= fill_i.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_q[s] <= '0;
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    age_q[s][w] <= 2'd0;
                end
            end
        end else begin
            if (lookup_en_i && lookup_o.hit) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    if (w[`ICACHE_WAY_BITS-1:0] == lookup_o.hit_way) begin
                        if (age_q[index_i][w] != 2'd0) begin
                            age_q[index_i][w] <= age_q[index_i][w] - 2'd1;  // younger
                        end
                    end else if (age_q[index_i][w] != 2'd3) begin
                        age_q[index_i][w] <= age_q[index_i][w] + 2'd1;      // older
                    end
                end
            end
            if (fill_en_i) begin
                valid_q[fill_i.index][fill_i.way] <= 1'b1;
                age_q[fill_i.index][fill_i.way]   <= 2'd0;
            end
        end
    end

    // parallel compare of all four ways
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_vec[w] = valid_q[index_i][w] && (tag_q[index_i][w] == tag_i);
        end
    end

    always_comb begin
        lookup_o.hit     = |hit_vec;
        lookup_o.hit_way = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                lookup_o.hit_way = w[`ICACHE_WAY_BITS-1:0];
            end
        end
    end

    // oldest way wins and the lowest index takes a tie
    // any empty way overrides the age choice
    always_comb begin
        logic [1:0] best_age;
        best_age            = age_q[index_i][0];
        lookup_o.victim_way = '0;
        for (int w = 1; w < `ICACHE_WAYS; w++) begin
            if (age_q[index_i][w] > best_age) begin
                best_age            = age_q[index_i][w];
                lookup_o.victim_way = w[`ICACHE_WAY_BITS-1:0];
            end
        end
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[index_i][w]) begin
                lookup_o.victim_way = w[`ICACHE_WAY_BITS-1:0];
            end
        end
    end

    // a line must never be resident in two ways of a set
    a_onehot_hit: assert property (
        @(posedge clk) disable iff (rst) $onehot0(hit_vec)
    ) else $error("tag store: multiple ways hit");

    a_no_lookup_during_fill: assert property (
        @(posedge clk) disable iff (rst) !(lookup_en_i && fill_en_i)
    ) else $error("tag store: lookup and fill in the same cycle");

endmodule

/* icache_tb.sv */
// instruction cache testbench
// table-driven requests against a reference model

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_tb;

    localparam int NSTEPS  = 21;
    localparam int TIMEOUT = 40;    // cycles allowed per wait

    typedef struct packed {
        logic [`ICACHE_ADDR_BITS-1:0] addr;
        logic [3:0]                   dly;      // cycles before consume
        logic                         clean;    // abandon once the refill starts
    } step_t;

    logic                          clk;
    logic                          rst;
    logic [`ICACHE_ADDR_BITS-1:0]  cpu_addr;
    logic                          cpu_valid;
    logic                          cpu_consume;
    logic                          cpu_clean;
    logic [`ICACHE_LINE_BITS-1:0]  cpu_data;
    logic                          cpu_ready;
    logic                          cache_clear;
    logic                          axi_valid;
    logic [`ICACHE_ADDR_BITS-1:0]  axi_addr;
    logic                          axi_ready;
    logic                          axi_last;
    logic [`ICACHE_BEAT_BITS-1:0]  axi_data;
    logic [`ICACHE_CNT_BITS-1:0]   hit_count;
    logic [`ICACHE_CNT_BITS-1:0]   miss_count;

    // reference model state
    logic [`ICACHE_TAG_BITS-1:0]   m_tag   [`ICACHE_SETS][`ICACHE_WAYS];
    logic                          m_valid [`ICACHE_SETS][`ICACHE_WAYS];
    int                            m_age   [`ICACHE_SETS][`ICACHE_WAYS];
    longint unsigned               m_hits;
    longint unsigned               m_misses;
    int                            errors;
    int                            checks;
    logic                          timed_out;

    // set 0x2a takes five tags and the age rule evicts t3
    step_t steps [NSTEPS] = '{
        '{32'h0000_1230, 4'd0, 1'b0}, '{32'h0000_1230, 4'd0, 1'b0},
        '{32'h0000_1234, 4'd0, 1'b0}, '{32'h0000_1238, 4'd0, 1'b0},
        '{32'h0000_123c, 4'd0, 1'b0}, '{32'h0000_0aa0, 4'd0, 1'b0},
        '{32'h0000_12a0, 4'd0, 1'b0}, '{32'h0000_1aa0, 4'd0, 1'b0},
        '{32'h0000_22a0, 4'd0, 1'b0}, '{32'h0000_0aa4, 4'd1, 1'b0},
        '{32'h0000_12a8, 4'd0, 1'b0}, '{32'h0000_2aa0, 4'd0, 1'b0},
        '{32'h0000_0aa0, 4'd0, 1'b0}, '{32'h0000_12a0, 4'd2, 1'b0},
        '{32'h0000_22ac, 4'd0, 1'b0}, '{32'h0000_2aa0, 4'd0, 1'b0},
        '{32'h0000_1aa0, 4'd0, 1'b0}, '{32'h0000_1230, 4'd6, 1'b0},
        '{32'h0000_4560, 4'd3, 1'b0}, '{32'h0000_7770, 4'd0, 1'b1},
        '{32'h0000_7770, 4'd0, 1'b0}
    };
    string names [NSTEPS] = '{
        "cold miss", "repeat hit", "offset 4", "offset 8", "offset c",
        "fill t1", "fill t2", "fill t3", "fill t4", "age hit t1", "age hit t2",
        "evict t5", "keep t1", "keep t2", "keep t4", "keep t5", "refetch t3",
        "consume delay hit", "consume delay miss", "abandon refill", "hit after abandon"
    };

    icache_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .cpu_addr_i    (cpu_addr),
        .cpu_valid_i   (cpu_valid),
        .cpu_consume_i (cpu_consume),
        .cpu_clean_i   (cpu_clean),
        .cpu_data_o    (cpu_data),
        .cpu_ready_o   (cpu_ready),
        .cache_clear_o (cache_clear),
        .axi_valid_o   (axi_valid),
        .axi_addr_o    (axi_addr),
        .axi_ready_i   (axi_ready),
        .axi_last_i    (axi_last),
        .axi_data_i    (axi_data),
        .hit_count_o   (hit_count),
        .miss_count_o  (miss_count)
    );

    icache_tb_mem mem_i (
        .clk         (clk),
        .axi_valid_i (axi_valid),
        .axi_addr_i  (axi_addr),
        .axi_ready_o (axi_ready),
        .axi_last_o  (axi_last),
        .axi_data_o  (axi_data)
    );

    always #50 clk = ~clk;

    // memory content behind a line with the low beat first
    function automatic logic [127:0] line_pattern(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:4], 4'h0};
        return {a + 32'h7f4a_7c15, a[15:0], a[31:16], a ^ 32'h9e37_79b9, ~a};
    endfunction

    // returns 1 on a hit and updates ages or fills the victim
    function automatic logic model_access(input logic [31:0] addr);
        logic [`ICACHE_TAG_BITS-1:0] tag;
        int                          idx;
        int                          way;
        tag = addr[31:11];
        idx = int'(addr[10:4]);
        way = -1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                way = w;
            end
        end
        if (way >= 0) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (w == way) begin
                    m_age[idx][w] = (m_age[idx][w] > 0) ? m_age[idx][w] - 1 : 0;
                end else begin
                    m_age[idx][w] = (m_age[idx][w] < 3) ? m_age[idx][w] + 1 : 3;
                end
            end
            m_hits++;
            return 1'b1;
        end
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!m_valid[idx][w]) way = w;  // lowest empty way
        end
        if (way < 0) begin
            way = 0;
            for (int w = 1; w < `ICACHE_WAYS; w++) begin
                if (m_age[idx][w] > m_age[idx][way]) way = w;  // strictly older only
            end
        end
        m_tag[idx][way]   = tag;
        m_valid[idx][way] = 1'b1;
        m_age[idx][way]   = 0;
        m_misses++;
        return 1'b0;
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        $display("timeout: %s, controller state %s", what, dut_i.u_ctrl.state_q.name());
    endtask

    task automatic run_step(input int n);
        step_t        s;
        logic         exp_hit;
        logic [127:0] exp_line;
        logic [31:0]  exp_addr;
        logic [127:0] held;
        int           cycles;
        s         = steps[n];
        exp_hit   = model_access(s.addr);
        exp_line  = line_pattern(s.addr);
        exp_addr  = {s.addr[31:4], 4'h0};   // line-aligned bus request
        cpu_addr  = s.addr;
        cpu_valid = 1'b1;
        cycles    = 0;
        if (s.clean) begin
            while (!axi_valid && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!axi_valid) begin
                report_timeout({names[n], " never started a refill"});
                return;
            end
            check_value({names[n], " bus address"}, exp_addr, axi_addr);
            cpu_clean = 1'b1;   // a single pulse that the refill must remember
            cpu_valid = 1'b0;
            @(negedge clk);
            cpu_clean = 1'b0;
        end else begin
            do begin
                @(negedge clk);
                cycles++;
                if (axi_valid) begin
                    check_value({names[n], " bus address"}, exp_addr, axi_addr);
                end
            end while (!cpu_ready && cycles < TIMEOUT);
            if (!cpu_ready) begin
                report_timeout({names[n], " got no ready"});
                return;
            end
            cpu_valid = 1'b0;
            if (exp_hit) check_value({names[n], " hit latency"}, 2, cycles);
            check_value({names[n], " line"}, exp_line, cpu_data);
            held = cpu_data;
            for (int i = 0; i < s.dly; i++) begin
                @(negedge clk);
                check_value({names[n], " ready held"}, 1'b1, cpu_ready);
                check_value({names[n], " data held"}, held, cpu_data);
                check_value({names[n], " busy"}, 1'b0, cache_clear);
            end
            cpu_consume = 1'b1;
            @(negedge clk);
            cpu_consume = 1'b0;
        end
        cycles = 0;
        while (!cache_clear && cycles < TIMEOUT) begin
            if (s.clean) check_value({names[n], " no ready"}, 1'b0, cpu_ready);
            @(negedge clk);
            cycles++;
        end
        if (!cache_clear) begin
            report_timeout({names[n], " did not return to idle"});
            return;
        end
        check_value({names[n], " ready low"}, 1'b0, cpu_ready);
        check_value({names[n], " hit count"}, m_hits, hit_count);
        check_value({names[n], " miss count"}, m_misses, miss_count);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        cpu_addr    = '0;
        cpu_valid   = 1'b0;
        cpu_consume = 1'b0;
        cpu_clean   = 1'b0;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        m_hits      = 0;
        m_misses    = 0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_age[s][w]   = 0;
            end
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        check_value("reset ready", 1'b0, cpu_ready);
        check_value("reset bus valid", 1'b0, axi_valid);
        check_value("reset hit count", 0, hit_count);
        check_value("reset miss count", 0, miss_count);
        check_value("reset idle", 1'b1, cache_clear);
        for (int n = 0; n < NSTEPS && !timed_out; n++) begin
            run_step(n);
        end
        if (!timed_out) begin
            check_value("final hits", m_hits, hit_count);
            check_value("final misses", m_misses, miss_count);
        end
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* icache_tb_mem.sv */
// bus responder for the cache testbench

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_tb_mem (
    input  logic                          clk,
    input  logic                          axi_valid_i,
    input  logic [`ICACHE_ADDR_BITS-1:0]  axi_addr_i,
    output logic                          axi_ready_o,
    output logic                          axi_last_o,
    output logic [`ICACHE_BEAT_BITS-1:0]  axi_data_o
);

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] beat_data(input logic [31:0] a, input logic hi);
        if (hi) begin
            return {a + 32'h7f4a_7c15, a[15:0], a[31:16]};
        end
        return {a ^ 32'h9e37_79b9, ~a};
    endfunction

    initial begin
        logic [31:0] lfsr;
        logic [31:0] line_addr;
        logic [1:0]  gap;
        lfsr        = 32'h2c5d_8b49;
        axi_ready_o = 1'b0;
        axi_last_o  = 1'b0;
        axi_data_o  = '0;
        forever begin
            @(negedge clk);
            if (axi_valid_i === 1'b1) begin
                line_addr = axi_addr_i;
                for (int b = 0; b < 2; b++) begin
                    for (int k = 0; k < 2; k++) begin
                        lfsr = lfsr_next(lfsr);
                        gap  = {gap[0], lfsr[0]};   // one step per bit
                    end
                    repeat (gap) @(negedge clk);
                    axi_ready_o = 1'b1;
                    axi_last_o  = (b == 1);
                    axi_data_o  = beat_data(line_addr, b[0]);
                    @(negedge clk);
                    axi_ready_o = 1'b0;
                    axi_last_o  = 1'b0;
                end
            end
        end
    end

endmodule

/* icache_top.sv */
// instruction cache top

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_top (
    input  logic                          clk,
    input  logic                          rst,
    // cpu
    input  logic [`ICACHE_ADDR_BITS-1:0]  cpu_addr_i,
    input  logic                          cpu_valid_i,
    input  logic                          cpu_consume_i,
    input  logic                          cpu_clean_i,
    output logic [`ICACHE_LINE_BITS-1:0]  cpu_data_o,
    output logic                          cpu_ready_o,
    output logic                          cache_clear_o,
    // read bus
    output logic                          axi_valid_o,
    output logic [`ICACHE_ADDR_BITS-1:0]  axi_addr_o,
    input  logic                          axi_ready_i,
    input  logic                          axi_last_i,
    input  logic [`ICACHE_BEAT_BITS-1:0]  axi_data_i,
    // counters
    output logic [`ICACHE_CNT_BITS-1:0]   hit_count_o,
    output logic [`ICACHE_CNT_BITS-1:0]   miss_count_o
);

    import icache_pkg::*;

    icache_lookup_t                 lookup;
    icache_fill_t                   fill;
    logic                           lookup_en;
    logic                           fill_en;
    logic [`ICACHE_IDX_BITS-1:0]    lookup_index;
    logic [`ICACHE_TAG_BITS-1:0]    lookup_tag;
    logic [`ICACHE_RAMS-1:0]        ram_ce;
    logic [`ICACHE_RAMS-1:0]        ram_we;
    logic [`ICACHE_RAM_AW-1:0]      ram_addr;
    logic [`ICACHE_LINE_BITS-1:0]   ram_wdata;
    logic [`ICACHE_RAMS-1:0][`ICACHE_LINE_BITS-1:0] ram_rdata;

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cpu_addr_i     (cpu_addr_i),
        .cpu_valid_i    (cpu_valid_i),
        .cpu_consume_i  (cpu_consume_i),
        .cpu_clean_i    (cpu_clean_i),
        .cpu_data_o     (cpu_data_o),
        .cpu_ready_o    (cpu_ready_o),
        .cache_clear_o  (cache_clear_o),
        .axi_valid_o    (axi_valid_o),
        .axi_addr_o     (axi_addr_o),
        .axi_ready_i    (axi_ready_i),
        .axi_last_i     (axi_last_i),
        .axi_data_i     (axi_data_i),
        .hit_count_o    (hit_count_o),
        .miss_count_o   (miss_count_o),
        .lookup_index_o (lookup_index),
        .lookup_tag_o   (lookup_tag),
        .lookup_en_o    (lookup_en),
        .fill_en_o      (fill_en),
        .fill_o         (fill),
        .lookup_i       (lookup),
        .ram_ce_o       (ram_ce),
        .ram_we_o       (ram_we),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata),
        .ram_rdata_i    (ram_rdata)
    );

    icache_tag_store u_tags (
        .clk         (clk),
        .rst         (rst),
        .index_i     (lookup_index),
        .tag_i       (lookup_tag),
        .lookup_en_i (lookup_en),
        .fill_en_i   (fill_en),
        .fill_i      (fill),
        .lookup_o    (lookup)
    );

    // two banks per way, lower and upper half of the sets
    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        for (genvar b = 0; b < 2; b++) begin : g_bank
            icache_sram u_sram (
                .clk     (clk),
                .ce_i    (ram_ce[w*2+b]),
                .we_i    (ram_we[w*2+b]),
                .addr_i  (ram_addr),
                .wdata_i (ram_wdata),
                .rdata_o (ram_rdata[w*2+b])
            );
        end
    end

endmodule

/* vlog.f */
+incdir+.
icache_pkg.sv
icache_sram.sv
icache_tag_store.sv
icache_ctrl.sv
icache_top.sv
icache_tb_mem.sv
icache_tb.sv
